// ==== design/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath widths
`define MIPS_DATA_WIDTH      32
`define MIPS_REG_ADDR_WIDTH  5
`define MIPS_REG_COUNT       32
`define MIPS_IMM_WIDTH       16
`define MIPS_SHAMT_WIDTH     5

// Primary opcodes, instr[31:26]
`define MIPS_OP_SPECIAL  6'b000000
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_SLTI     6'b001010
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_XORI     6'b001110
`define MIPS_OP_LUI      6'b001111

// SPECIAL funct codes, instr[5:0]
`define MIPS_FN_SLL      6'b000000
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_SRA      6'b000011
`define MIPS_FN_SLLV     6'b000100
`define MIPS_FN_SRLV     6'b000110
`define MIPS_FN_SRAV     6'b000111
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_NOR      6'b100111
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_SLTU     6'b101011

`endif

// ==== design/mips_pkg.sv ====
`default_nettype none

`include "mips_settings.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_WIDTH-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`MIPS_SHAMT_WIDTH-1:0]    shamt_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        shift_sll,
        shift_srl,
        shift_sra
    } shift_op_e;

    typedef enum logic {
        res_alu,
        res_shift
    } res_sel_e;

    // Decoded controls carried into execute
    typedef struct packed {
        alu_op_e   alu_op;
        shift_op_e shift_op;
        res_sel_e  res_sel;
        logic      b_is_imm;
        logic      shamt_from_rs;
        logic      reg_w;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm_ext;
    } id_ex_t;

    // Shared by ex_mem and mem_wb
    typedef struct packed {
        logic      valid;
        logic      reg_w;
        reg_addr_t rd;
        word_t     result;
    } wb_t;

endpackage

`default_nettype wire

// ==== design/instr_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_settings.svh"

module instr_decoder
    import mips_pkg::*;
(
    input  word_t     instr,
    output ctrl_t     ctrl,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output reg_addr_t rd,
    output shamt_t    shamt,
    output word_t     imm_ext
);

    logic [5:0]                   opcode;
    logic [5:0]                   funct;
    logic [`MIPS_IMM_WIDTH-1:0]   imm;
    reg_addr_t                    rs_f;
    reg_addr_t                    rt_f;
    reg_addr_t                    rd_f;

    logic      known;
    logic      imm_form;
    logic      zero_ext;
    logic      upper_imm;
    reg_addr_t dest;

    assign opcode = instr[31:26];
    assign rs_f   = instr[25:21];
    assign rt_f   = instr[20:16];
    assign rd_f   = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[`MIPS_IMM_WIDTH-1:0];

    always_comb begin
        ctrl.alu_op        = alu_add;
        ctrl.shift_op      = shift_sll;
        ctrl.res_sel       = res_alu;
        ctrl.shamt_from_rs = 1'b0;
        known              = 1'b1;
        imm_form           = 1'b1;
        zero_ext           = 1'b0;
        upper_imm          = 1'b0;

        case (opcode)
            `MIPS_OP_SPECIAL: begin
                imm_form = 1'b0;
                case (funct)
                    `MIPS_FN_ADDU: ctrl.alu_op = alu_add;
                    `MIPS_FN_SUBU: ctrl.alu_op = alu_sub;
                    `MIPS_FN_AND:  ctrl.alu_op = alu_and;
                    `MIPS_FN_OR:   ctrl.alu_op = alu_or;
                    `MIPS_FN_XOR:  ctrl.alu_op = alu_xor;
                    `MIPS_FN_NOR:  ctrl.alu_op = alu_nor;
                    `MIPS_FN_SLT:  ctrl.alu_op = alu_slt;
                    `MIPS_FN_SLTU: ctrl.alu_op = alu_sltu;
                    `MIPS_FN_SLL, `MIPS_FN_SLLV: ctrl.shift_op = shift_sll;
                    `MIPS_FN_SRL, `MIPS_FN_SRLV: ctrl.shift_op = shift_srl;
                    `MIPS_FN_SRA, `MIPS_FN_SRAV: ctrl.shift_op = shift_sra;
                    default:       known = 1'b0;
                endcase
                // Shift group sits in the low funct codes
                if (known && funct[5:3] == 3'b000) begin
                    ctrl.res_sel       = res_shift;
                    ctrl.shamt_from_rs = funct[2];
                end
            end
            `MIPS_OP_ADDIU: ctrl.alu_op = alu_add;
            `MIPS_OP_SLTI:  ctrl.alu_op = alu_slt;
            `MIPS_OP_ANDI: begin
                ctrl.alu_op = alu_and;
                zero_ext    = 1'b1;
            end
            `MIPS_OP_ORI: begin
                ctrl.alu_op = alu_or;
                zero_ext    = 1'b1;
            end
            `MIPS_OP_XORI: begin
                ctrl.alu_op = alu_xor;
                zero_ext    = 1'b1;
            end
            // rs is forced to 0 below, so OR just passes the shifted immediate
            `MIPS_OP_LUI: begin
                ctrl.alu_op = alu_or;
                upper_imm   = 1'b1;
            end
            default: known = 1'b0;
        endcase

        // I-type writes rt, R-type writes rd
        dest          = imm_form ? rt_f : rd_f;
        ctrl.b_is_imm = imm_form;
        ctrl.reg_w    = known && (dest != '0);
    end

    // Immediate extension
    always_comb begin
        imm_ext = {{(`MIPS_DATA_WIDTH - `MIPS_IMM_WIDTH){imm[`MIPS_IMM_WIDTH-1]}}, imm};
        if (zero_ext) begin
            imm_ext = {{(`MIPS_DATA_WIDTH - `MIPS_IMM_WIDTH){1'b0}}, imm};
        end
        if (upper_imm) begin
            imm_ext = {imm, {(`MIPS_DATA_WIDTH - `MIPS_IMM_WIDTH){1'b0}}};
        end
    end

    assign rs = upper_imm ? '0 : rs_f;
    assign rt = rt_f;
    assign rd = dest;

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic      ui_clk_from_ddr,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    input  wb_t       wr
);

    localparam int unsigned reg_count = 2 ** $bits(reg_addr_t);

    word_t regs [reg_count];
    logic  wr_en;

    // Write from the writeback stage
    assign wr_en = wr.valid && wr.reg_w;

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.result;
        end
    end

    // Read with write-through from the writeback stage
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr.rd == addr) begin
            return wr.result;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    zero_reg_held: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        regs[0] == '0)
        else $error("reg_file: register 0 holds %h", regs[0]);

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module exec_unit
    import mips_pkg::*;
(
    input  id_ex_t stage,
    input  wb_t    fwd_mem,
    input  wb_t    fwd_wb,
    output wb_t    result
);

    word_t  op_a;
    word_t  op_rt;
    word_t  op_b;
    word_t  alu_out;
    word_t  shift_out;
    shamt_t shift_amt;

    //////////////////////////////////////////////////
    // Operand forwarding
    //////////////////////////////////////////////////

    // Memory stage is younger, so it wins over writeback
    function automatic word_t forward(
        input reg_addr_t src,
        input word_t     reg_val,
        input wb_t       mem_e,
        input wb_t       wb_e
    );
        if (src == '0) begin
            return reg_val;
        end
        if (mem_e.valid && mem_e.reg_w && mem_e.rd == src) begin
            return mem_e.result;
        end
        if (wb_e.valid && wb_e.reg_w && wb_e.rd == src) begin
            return wb_e.result;
        end
        return reg_val;
    endfunction

    assign op_a  = forward(stage.rs, stage.rs_val, fwd_mem, fwd_wb);
    assign op_rt = forward(stage.rt, stage.rt_val, fwd_mem, fwd_wb);
    assign op_b  = stage.ctrl.b_is_imm ? stage.imm_ext : op_rt;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (stage.ctrl.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_or:   alu_out = op_a | op_b;
            alu_xor:  alu_out = op_a ^ op_b;
            alu_nor:  alu_out = ~(op_a | op_b);
            alu_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_out = word_t'(op_a < op_b);
            default:  alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Barrel shifter
    //////////////////////////////////////////////////

    // Variable shifts use the low bits of rs only
    assign shift_amt = stage.ctrl.shamt_from_rs ? op_a[$bits(shamt_t)-1:0] : stage.shamt;

    always_comb begin
        case (stage.ctrl.shift_op)
            shift_sll: shift_out = op_rt << shift_amt;
            shift_srl: shift_out = op_rt >> shift_amt;
            shift_sra: shift_out = word_t'($signed(op_rt) >>> shift_amt);
            default:   shift_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result to the memory stage
    //////////////////////////////////////////////////

    always_comb begin
        result.valid  = stage.valid;
        result.reg_w  = stage.ctrl.reg_w;
        result.rd     = stage.rd;
        result.result = (stage.ctrl.res_sel == res_shift) ? shift_out : alu_out;
    end

    // Catches undriven register reads or unforwarded operands
    always_comb begin
        if (stage.valid) begin
            result_known: assert final (!$isunknown(result.result))
                else $error("exec_unit: unknown result for rd %0d", stage.rd);
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ps

module mips_pipeline
    import mips_pkg::*;
(
    input  logic      ui_clk_from_ddr,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    // Fetch to decode
    logic   if_id_valid;
    word_t  if_id_instr;

    // Later stage registers
    id_ex_t id_ex;
    id_ex_t id_ex_next;
    wb_t    ex_mem;
    wb_t    mem_wb;

    // Decode outputs
    ctrl_t     dec_ctrl;
    reg_addr_t dec_rs;
    reg_addr_t dec_rt;
    reg_addr_t dec_rd;
    shamt_t    dec_shamt;
    word_t     dec_imm_ext;
    word_t     rs_val;
    word_t     rt_val;

    wb_t    ex_result;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    instr_decoder instr_decoder_inst (
        .instr   ( if_id_instr ),
        .ctrl    ( dec_ctrl    ),
        .rs      ( dec_rs      ),
        .rt      ( dec_rt      ),
        .rd      ( dec_rd      ),
        .shamt   ( dec_shamt   ),
        .imm_ext ( dec_imm_ext )
    );

    // Written from mem_wb, read in decode
    reg_file reg_file_inst (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .rs_addr         ( dec_rs          ),
        .rt_addr         ( dec_rt          ),
        .rs_data         ( rs_val          ),
        .rt_data         ( rt_val          ),
        .wr              ( mem_wb          )
    );

    always_comb begin
        id_ex_next.valid      = if_id_valid;
        id_ex_next.ctrl       = dec_ctrl;
        // A bubble must not write
        id_ex_next.ctrl.reg_w = dec_ctrl.reg_w && if_id_valid;
        id_ex_next.rs         = dec_rs;
        id_ex_next.rt         = dec_rt;
        id_ex_next.rd         = dec_rd;
        id_ex_next.shamt      = dec_shamt;
        id_ex_next.rs_val     = rs_val;
        id_ex_next.rt_val     = rt_val;
        id_ex_next.imm_ext    = dec_imm_ext;
    end

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    exec_unit exec_unit_inst (
        .stage   ( id_ex     ),
        .fwd_mem ( ex_mem    ),
        .fwd_wb  ( mem_wb    ),
        .result  ( ex_result )
    );

    //////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            if_id_valid <= 1'b0;
            if_id_instr <= '0;
            id_ex       <= '0;
            ex_mem      <= '0;
            mem_wb      <= '0;
        end else begin
            if_id_valid <= instr_valid;
            if (instr_valid) begin
                if_id_instr <= instr;
            end
            id_ex  <= id_ex_next;
            ex_mem <= ex_result;
            // Memory stage only delays the result
            mem_wb <= ex_mem;
        end
    end

    // Writeback port
    assign wb_valid = mem_wb.valid && mem_wb.reg_w;
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_wb.result;

    wb_never_zero: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        wb_valid |-> (wb_rd != '0))
        else $error("mips_pipeline: writeback to register 0");

endmodule

`default_nettype wire

// ==== dv/tb_mips_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mips_settings.svh"

module tb_mips_pipeline;

    // Slot budget per test with idle gaps counted at their maximum
    localparam int drain_slots    = 12;
    localparam int issue_slots    = 18 + 200 + 180 + 180 + 40 + 1200;
    localparam int timeout_cycles = (issue_slots + 6 * drain_slots + 20) * 2;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        int          due;
    } pending_t;

    logic        ui_clk_from_ddr;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    pending_t    pending_q[$];
    pending_t    head;
    logic [31:0] model_regs [32];
    int          cycle = 0;
    string       test_name = "reset";
    int          errors;
    int          errors_start;
    int          tests_run;
    int          tests_failed;

    mips_pipeline mips_pipeline_inst (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .instr_valid     ( instr_valid     ),
        .instr           ( instr           ),
        .wb_valid        ( wb_valid        ),
        .wb_rd           ( wb_rd           ),
        .wb_data         ( wb_data         )
    );

    initial begin
        ui_clk_from_ddr = 1'b0;
        forever #2 ui_clk_from_ddr = ~ui_clk_from_ddr;
    end

    always @(posedge ui_clk_from_ddr) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("ERROR: timeout after %0d cycles in test %s", cycle, test_name);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s in test %s", msg, test_name);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        errors_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", test_name, errors - errors_start);
        end
    endtask

    //////////////////////////////////////////////////
    // Instruction encoding and random choice
    //////////////////////////////////////////////////

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Narrow range forces dependencies
    function automatic logic [4:0] pick_reg(input bit wide);
        if (wide) begin
            return 5'(1 + $urandom % 31);
        end
        if ($urandom % 8 == 0) begin
            return 5'($urandom);
        end
        return 5'(1 + $urandom % 7);
    endfunction

    function automatic logic [31:0] unknown_instr();
        logic [31:0] w;
        w = $urandom;
        case ($urandom % 4)
            0: w[31:26] = 6'b100011;
            1: w[31:26] = 6'b101011;
            2: w[31:26] = 6'b000100;
            default: w = {`MIPS_OP_SPECIAL, w[25:6], 6'b011000};
        endcase
        return w;
    endfunction

    function automatic logic [5:0] shift_fn(input int k);
        case (k)
            0: return `MIPS_FN_SLL;
            1: return `MIPS_FN_SRL;
            2: return `MIPS_FN_SRA;
            3: return `MIPS_FN_SLLV;
            4: return `MIPS_FN_SRLV;
            default: return `MIPS_FN_SRAV;
        endcase
    endfunction

    function automatic logic [31:0] random_instr(input bit allow_unknown, input bit wide);
        int          kind;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        kind = int'($urandom % (allow_unknown ? 22 : 20));
        rs   = pick_reg(wide);
        rt   = pick_reg(wide);
        rd   = pick_reg(wide);
        sa   = 5'd0;
        imm  = 16'($urandom);
        case (kind)
            0:  fn = `MIPS_FN_ADDU;
            1:  fn = `MIPS_FN_SUBU;
            2:  fn = `MIPS_FN_AND;
            3:  fn = `MIPS_FN_OR;
            4:  fn = `MIPS_FN_XOR;
            5:  fn = `MIPS_FN_NOR;
            6:  fn = `MIPS_FN_SLT;
            7:  fn = `MIPS_FN_SLTU;
            8, 9, 10: begin
                fn = shift_fn(kind - 8);
                sa = 5'($urandom);
            end
            11, 12, 13: fn = shift_fn(kind - 8);
            14: return i_type(`MIPS_OP_ADDIU, rs, rt, imm);
            15: return i_type(`MIPS_OP_SLTI, rs, rt, imm);
            16: return i_type(`MIPS_OP_ANDI, rs, rt, imm);
            17: return i_type(`MIPS_OP_ORI, rs, rt, imm);
            18: return i_type(`MIPS_OP_XORI, rs, rt, imm);
            19: return i_type(`MIPS_OP_LUI, 5'd0, rt, imm);
            default: return unknown_instr();
        endcase
        return r_type(fn, rs, rt, rd, sa);
    endfunction

    function automatic logic [31:0] set_dest(input logic [31:0] w, input logic [4:0] dst);
        logic [31:0] r;
        r = w;
        if (w[31:26] == `MIPS_OP_SPECIAL) begin
            r[15:11] = dst;
        end else begin
            r[20:16] = dst;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Architectural model
    //////////////////////////////////////////////////

    task automatic model_issue(input logic [31:0] w, input int accept_cycle);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] value;
        bit          known;
        pending_t    entry;

        op    = w[31:26];
        fn    = w[5:0];
        sa    = w[10:6];
        a     = model_regs[w[25:21]];
        b     = model_regs[w[20:16]];
        sext  = {{16{w[15]}}, w[15:0]};
        zext  = {16'h0000, w[15:0]};
        dest  = w[20:16];
        value = '0;
        known = 1'b1;

        case (op)
            `MIPS_OP_SPECIAL: begin
                dest = w[15:11];
                case (fn)
                    `MIPS_FN_ADDU: value = a + b;
                    `MIPS_FN_SUBU: value = a - b;
                    `MIPS_FN_AND:  value = a & b;
                    `MIPS_FN_OR:   value = a | b;
                    `MIPS_FN_XOR:  value = a ^ b;
                    `MIPS_FN_NOR:  value = ~(a | b);
                    `MIPS_FN_SLT:  value = {31'd0, $signed(a) < $signed(b)};
                    `MIPS_FN_SLTU: value = {31'd0, a < b};
                    `MIPS_FN_SLL:  value = b << sa;
                    `MIPS_FN_SRL:  value = b >> sa;
                    `MIPS_FN_SRA:  value = $signed(b) >>> sa;
                    `MIPS_FN_SLLV: value = b << a[4:0];
                    `MIPS_FN_SRLV: value = b >> a[4:0];
                    `MIPS_FN_SRAV: value = $signed(b) >>> a[4:0];
                    default:       known = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: value = a + sext;
            `MIPS_OP_SLTI:  value = {31'd0, $signed(a) < $signed(sext)};
            `MIPS_OP_ANDI:  value = a & zext;
            `MIPS_OP_ORI:   value = a | zext;
            `MIPS_OP_XORI:  value = a ^ zext;
            `MIPS_OP_LUI:   value = {w[15:0], 16'h0000};
            default:        known = 1'b0;
        endcase

        if (known && dest != 5'd0) begin
            model_regs[dest] = value;
            entry.rd   = dest;
            entry.data = value;
            entry.due  = accept_cycle + 3;
            pending_q.push_back(entry);
        end
    endtask

    //////////////////////////////////////////////////
    // Driving and checking
    //////////////////////////////////////////////////

    task automatic issue(input logic [31:0] w);
        @(posedge ui_clk_from_ddr);
        #1;
        instr_valid = 1'b1;
        instr       = w;
        model_issue(w, cycle + 1);
    endtask

    // Junk on instr while invalid
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge ui_clk_from_ddr);
            #1;
            instr_valid = 1'b0;
            instr       = $urandom;
        end
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        issue(i_type(`MIPS_OP_LUI, 5'd0, r, v[31:16]));
        issue(i_type(`MIPS_OP_ORI, r, r, v[15:0]));
    endtask

    task automatic drain();
        idle(1);
        while (pending_q.size() != 0) begin
            @(posedge ui_clk_from_ddr);
        end
        // Room for a stray late writeback
        idle(6);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge ui_clk_from_ddr) begin
        if (!reset) begin
            if (wb_valid) begin
                if (pending_q.size() == 0) begin
                    report_failure($sformatf("unexpected writeback to r%0d", wb_rd));
                end else begin
                    head = pending_q.pop_front();
                    if (wb_rd !== head.rd) begin
                        report_mismatch("rd", 32'(head.rd), 32'(wb_rd));
                    end
                    if (wb_data !== head.data) begin
                        report_mismatch($sformatf("data r%0d", head.rd), head.data, wb_data);
                    end
                    if (cycle != head.due) begin
                        report_mismatch("writeback cycle", 32'(head.due), 32'(cycle));
                    end
                end
            end else if (pending_q.size() != 0 && pending_q[0].due <= cycle) begin
                report_failure($sformatf("no writeback for r%0d due at cycle %0d",
                                         pending_q[0].rd, pending_q[0].due));
                void'(pending_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] w;
        logic [31:0] v;
        logic [4:0]  dst;
        logic [4:0]  amt;

        void'($urandom(32'h3b78e259));
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        errors       = 0;
        errors_start = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge ui_clk_from_ddr);
        #1;
        reset = 1'b0;

        // Idle pipeline, then back to back issue
        begin_test("latency");
        idle(10);
        for (int r = 1; r <= 8; r++) begin
            issue(i_type(`MIPS_OP_ADDIU, 5'd0, 5'(r), 16'($urandom)));
        end
        drain();
        end_test();

        begin_test("alu_immediate");
        for (int r = 1; r < 32; r++) begin
            load_reg(5'(r), $urandom);
        end
        load_reg(5'd1, 32'hffff_fff0);
        load_reg(5'd2, 32'h0000_0020);
        issue(r_type(`MIPS_FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(r_type(`MIPS_FN_SUBU, 5'd2, 5'd1, 5'd4, 5'd0));
        issue(r_type(`MIPS_FN_SLT, 5'd1, 5'd2, 5'd5, 5'd0));
        issue(r_type(`MIPS_FN_SLTU, 5'd1, 5'd2, 5'd6, 5'd0));
        issue(i_type(`MIPS_OP_ADDIU, 5'd1, 5'd7, 16'h7fff));
        issue(i_type(`MIPS_OP_ANDI, 5'd1, 5'd8, 16'h8001));
        issue(i_type(`MIPS_OP_SLTI, 5'd2, 5'd9, 16'hffff));
        repeat (120) begin
            issue(random_instr(1'b0, 1'b1));
        end
        drain();
        end_test();

        // Distance 1 and 2 hit forwarding, distance 3 the register file bypass
        begin_test("forwarding");
        for (int d = 1; d <= 3; d++) begin
            repeat (20) begin
                dst = 5'(1 + $urandom % 7);
                issue(set_dest(random_instr(1'b0, 1'b0), dst));
                for (int k = 0; k < d - 1; k++) begin
                    issue(i_type(`MIPS_OP_ADDIU, 5'd0, 5'(8 + k), 16'($urandom)));
                end
                w = random_instr(1'b0, 1'b0);
                if (w[31:26] == `MIPS_OP_SPECIAL) begin
                    if ($urandom % 3 != 1) begin
                        w[25:21] = dst;
                    end
                    if ($urandom % 3 != 0) begin
                        w[20:16] = dst;
                    end
                end else begin
                    w[25:21] = dst;
                end
                issue(w);
            end
        end
        drain();
        end_test();

        // Variable shifts carry a different shamt field than the rs amount
        begin_test("shifts");
        for (int k = 0; k < 6; k++) begin
            for (int j = 0; j < 6; j++) begin
                amt = (j == 0) ? 5'd0 : (j == 1) ? 5'd31 : 5'($urandom);
                v   = $urandom;
                if (j % 2 == 0) begin
                    v[31] = 1'b1;
                end
                load_reg(5'd2, v);
                load_reg(5'd3, {27'($urandom), amt});
                issue(r_type(shift_fn(k), (k < 3) ? 5'd0 : 5'd3, 5'd2, 5'd4,
                             (k < 3) ? amt : ~amt));
            end
        end
        drain();
        end_test();

        begin_test("no_writeback");
        repeat (8) begin
            issue(set_dest(random_instr(1'b0, 1'b0), 5'd0));
            issue(unknown_instr());
            idle(1 + $urandom % 2);
        end
        issue(r_type(`MIPS_FN_ADDU, 5'd0, 5'd0, 5'd5, 5'd0));
        issue(r_type(`MIPS_FN_OR, 5'd0, 5'd0, 5'd6, 5'd0));
        issue(i_type(`MIPS_OP_ORI, 5'd0, 5'd7, 16'h0000));
        drain();
        end_test();

        begin_test("long_random");
        repeat (400) begin
            issue(random_instr(1'b1, 1'b0));
            if ($urandom % 4 == 0) begin
                idle(1 + $urandom % 2);
            end
        end
        drain();
        end_test();

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/mips_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/mips_pipeline.sv
dv/tb_mips_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator

rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_mips_pipeline \
    -f sim.f -Mdir obj_dir \
    && ./obj_dir/Vtb_mips_pipeline > sim.log 2>&1 \
    || echo "build or run error"

grep -q "all tests passed" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
exit 0
